// ==== rtl/corr_pkg.sv ====
package corr_pkg;

   //--------------------------------------------------------------------------
   // Array geometry
   //--------------------------------------------------------------------------
   localparam int N_ANT      = 8;    // One-bit antenna streams
   localparam int N_PAIRS    = 14;   // Pairs per visibility block
   localparam int N_BLOCKS   = 2;    // Visibility blocks
   localparam int ACCUM_BITS = 16;   // Width of every accumulator

   localparam int N_ALL_PAIRS = N_BLOCKS * N_PAIRS;   // All 28 baselines

   // Block length minus one after reset
   localparam int BLOCKSIZE_RST = 15;

   //--------------------------------------------------------------------------
   // Baseline tables
   //--------------------------------------------------------------------------
   // Lexical order (0,1) (0,2) .. (6,7); block b owns b*14 .. b*14+13
   localparam int PAIR_A [N_ALL_PAIRS] = '{
      0, 0, 0, 0, 0, 0, 0,
      1, 1, 1, 1, 1, 1,
      2, 2, 2, 2, 2,
      3, 3, 3, 3,
      4, 4, 4,
      5, 5,
      6
   };

   localparam int PAIR_B [N_ALL_PAIRS] = '{
      1, 2, 3, 4, 5, 6, 7,
      2, 3, 4, 5, 6, 7,
      3, 4, 5, 6, 7,
      4, 5, 6, 7,
      5, 6, 7,
      6, 7,
      7
   };

   typedef logic [N_ANT-1:0]      ant_t;     // One bit per antenna
   typedef logic [ACCUM_BITS-1:0] count_t;   // One accumulated count

   // Hilbert output, 17 bits
   typedef struct packed {
      logic valid;   // Sample strobe, one cycle
      ant_t re;      // In-phase bits
      ant_t im;      // Quadrature bits
   } sample_t;

endpackage

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

   localparam int WB_AW   = 8;    // Word address
   localparam int WB_DW   = 32;   // Data
   localparam int N_UNITS = 4;    // Slaves behind the decoder

   // Master to slave
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

   //--------------------------------------------------------------------------
   // Address map, unit in adr[7:6]
   //--------------------------------------------------------------------------
   typedef logic [1:0] unit_t;

   localparam unit_t UNIT_VIS0 = 2'd0;   // Pairs 0..13
   localparam unit_t UNIT_VIS1 = 2'd1;   // Pairs 14..27
   localparam unit_t UNIT_ONES = 2'd2;   // Per-antenna ones
   localparam unit_t UNIT_CTRL = 2'd3;   // Acquisition registers

   // Register indexes inside UNIT_CTRL
   localparam logic [5:0] REG_CTRL      = 6'd0;
   localparam logic [5:0] REG_BLOCKSIZE = 6'd1;
   localparam logic [5:0] REG_BLOCKCNT  = 6'd2;

endpackage

// ==== rtl/hilbert_approx.sv ====
`timescale 1ns/10ps

module hilbert_approx
   import corr_pkg::*;
(
   input  logic    clk_i,
   input  logic    sw_d,
   input  logic    enable_i,
   input  logic    strobe_i,
   input  ant_t    antenna_i,
   output sample_t sample_o
);

   logic valid_q;   // Follows the enabled strobe
   logic primed;    // A previous strobe exists since enable
   ant_t re_q;
   ant_t im_q;

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         valid_q <= 1'b0;
         primed  <= 1'b0;
      end else begin
         valid_q <= enable_i && strobe_i;
         if (!enable_i)
            primed <= 1'b0;                 // Restart the quadrature history
         else if (strobe_i)
            primed <= 1'b1;
      end
   end

   // Crude quadrature, the previous strobe's bits stand in for a 90 deg shift
   always_ff @(posedge clk_i) begin
      if (enable_i && strobe_i) begin
         re_q <= antenna_i;
         im_q <= primed ? re_q : '0;        // Zero on the first strobe
      end
   end

   assign sample_o = '{valid: valid_q, re: re_q, im: im_q};

endmodule

// ==== rtl/vis_block.sv ====
`timescale 1ns/10ps

module vis_block
   import corr_pkg::*;
   import bus_pkg::*;
#(
   parameter int BLOCK_ID = 0   // Selects the pair slice
) (
   input  logic    clk_i,
   input  logic    sw_d,
   input  sample_t sample_i,
   input  logic    swap_i,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o
);

   localparam int BASE = BLOCK_ID * N_PAIRS;   // First table entry

   logic [N_PAIRS-1:0] cos_hit;     // re_a == re_b
   logic [N_PAIRS-1:0] sin_hit;     // re_a == im_b
   logic [N_PAIRS-1:0] cos_hit_q;
   logic [N_PAIRS-1:0] sin_hit_q;
   logic               hit_v;       // Registered sample valid
   logic               wr_bank;     // Bank being accumulated
   count_t             cos_q [2][N_PAIRS];
   count_t             sin_q [2][N_PAIRS];
   logic               ack_q;
   logic [WB_DW-1:0]   dat_q;
   logic [4:0]         idx;

   //--------------------------------------------------------------------------
   // Pair comparison, one register stage
   //--------------------------------------------------------------------------
   always_comb begin
      for (int p = 0; p < N_PAIRS; p++) begin
         cos_hit[p] = sample_i.re[PAIR_A[BASE+p]] ~^ sample_i.re[PAIR_B[BASE+p]];
         sin_hit[p] = sample_i.re[PAIR_A[BASE+p]] ~^ sample_i.im[PAIR_B[BASE+p]];
      end
   end

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)
         hit_v <= 1'b0;
      else
         hit_v <= sample_i.valid;
   end

   always_ff @(posedge clk_i) begin
      cos_hit_q <= cos_hit;
      sin_hit_q <= sin_hit;
   end

   //--------------------------------------------------------------------------
   // Double-buffered accumulators
   //--------------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         wr_bank <= 1'b0;
         for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < N_PAIRS; p++) begin
               cos_q[b][p] <= '0;
               sin_q[b][p] <= '0;
            end
         end
      end else begin
         if (swap_i)
            wr_bank <= ~wr_bank;            // Finished bank becomes readable
         for (int p = 0; p < N_PAIRS; p++) begin
            if (hit_v) begin                // Last sample still lands in old bank
               cos_q[wr_bank][p] <= cos_q[wr_bank][p] + count_t'(cos_hit_q[p]);
               sin_q[wr_bank][p] <= sin_q[wr_bank][p] + count_t'(sin_hit_q[p]);
            end
            if (swap_i) begin               // New write bank starts from zero
               cos_q[~wr_bank][p] <= '0;
               sin_q[~wr_bank][p] <= '0;
            end
         end
      end
   end

   //--------------------------------------------------------------------------
   // Read port, sin in the upper half
   //--------------------------------------------------------------------------
   assign idx = wb_i.adr[4:0];

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)
         ack_q <= 1'b0;
      else
         ack_q <= wb_i.cyc && wb_i.stb && !ack_q;   // Single-cycle ack
   end

   always_ff @(posedge clk_i) begin
      if (!wb_i.we && idx < 5'(N_PAIRS))
         dat_q <= {sin_q[~wr_bank][idx[3:0]], cos_q[~wr_bank][idx[3:0]]};
      else
         dat_q <= '0;                       // Unmapped index or write
   end

   assign wb_o = '{ack: ack_q, dat: dat_q};

   // Swap lands with the block's last sample, so it closes the old bank
   a_swap_on_sample: assert property (@(posedge clk_i) disable iff (sw_d)
      swap_i |-> hit_v);

endmodule

// ==== rtl/ones_counter.sv ====
`timescale 1ns/10ps

module ones_counter
   import corr_pkg::*;
   import bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    sw_d,
   input  sample_t sample_i,
   input  logic    swap_i,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o
);

   ant_t             ones_q;        // Registered re bits
   logic             ones_v;
   logic             wr_bank;
   count_t           cnt_q [2][N_ANT];
   logic             ack_q;
   logic [WB_DW-1:0] dat_q;
   logic [5:0]       idx;

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)
         ones_v <= 1'b0;
      else
         ones_v <= sample_i.valid;
   end

   always_ff @(posedge clk_i)
      ones_q <= sample_i.re;

   // Same bank discipline as the visibility blocks
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         wr_bank <= 1'b0;
         for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < N_ANT; a++)
               cnt_q[b][a] <= '0;
         end
      end else begin
         if (swap_i)
            wr_bank <= ~wr_bank;
         for (int a = 0; a < N_ANT; a++) begin
            if (ones_v)
               cnt_q[wr_bank][a] <= cnt_q[wr_bank][a] + count_t'(ones_q[a]);
            if (swap_i)
               cnt_q[~wr_bank][a] <= '0;   // Clear the next write bank
         end
      end
   end

   //--------------------------------------------------------------------------
   // Read port
   //--------------------------------------------------------------------------
   assign idx = wb_i.adr[5:0];

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)
         ack_q <= 1'b0;
      else
         ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
   end

   always_ff @(posedge clk_i) begin
      if (!wb_i.we && idx < 6'(N_ANT))
         dat_q <= WB_DW'(cnt_q[~wr_bank][idx[2:0]]);   // Zero-extended
      else
         dat_q <= '0;
   end

   assign wb_o = '{ack: ack_q, dat: dat_q};

   // The wrapping sample must be accumulated on the swap edge
   a_swap_on_sample: assert property (@(posedge clk_i) disable iff (sw_d)
      swap_i |-> ones_v);

endmodule

// ==== rtl/acq_control.sv ====
`timescale 1ns/10ps

module acq_control
   import corr_pkg::*;
   import bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    sw_d,
   input  logic    strobe_i,
   output logic    enable_o,
   output logic    swap_o,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o
);

   logic             en_q;          // REG_CTRL bit 0
   logic             active;        // First strobe seen since enable
   count_t           blocksize;     // Block length minus one
   count_t           block_cnt;     // Completed blocks
   count_t           strobe_cnt;
   logic             wrap_q;        // First delay stage
   logic             cnt_stb;
   logic             wrap;
   logic             bus_acc;
   logic [5:0]       reg_idx;
   logic             ack_q;
   logic [WB_DW-1:0] dat_q;

   assign bus_acc  = wb_i.cyc && wb_i.stb && !ack_q;
   assign reg_idx  = wb_i.adr[5:0];
   assign enable_o = en_q && (active || strobe_i);   // Opens on the first strobe
   assign cnt_stb  = strobe_i && enable_o;
   assign wrap     = strobe_cnt >= blocksize;        // Also catches a shrunk size

   //--------------------------------------------------------------------------
   // Register writes
   //--------------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         en_q      <= 1'b0;
         blocksize <= count_t'(BLOCKSIZE_RST);
         ack_q     <= 1'b0;
      end else begin
         ack_q <= bus_acc;
         if (bus_acc && wb_i.we) begin
            case (reg_idx)
               REG_CTRL:      en_q      <= wb_i.dat[0];
               REG_BLOCKSIZE: blocksize <= wb_i.dat[ACCUM_BITS-1:0];
               default:       ;              // REG_BLOCKCNT is read-only
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      case (reg_idx)
         REG_CTRL:      dat_q <= WB_DW'(en_q);
         REG_BLOCKSIZE: dat_q <= WB_DW'(blocksize);
         REG_BLOCKCNT:  dat_q <= WB_DW'(block_cnt);
         default:       dat_q <= '0;
      endcase
   end

   assign wb_o = '{ack: ack_q, dat: dat_q};

   //--------------------------------------------------------------------------
   // Block counting, swap lands as the wrapping sample is accumulated
   //--------------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         active     <= 1'b0;
         strobe_cnt <= '0;
         wrap_q     <= 1'b0;
         swap_o     <= 1'b0;
         block_cnt  <= '0;
      end else begin
         wrap_q <= cnt_stb && wrap;
         swap_o <= wrap_q;                        // Two edges after the strobe
         if (swap_o)
            block_cnt <= block_cnt + count_t'(1); // Same edge the banks swap
         if (!en_q) begin
            active     <= 1'b0;
            strobe_cnt <= '0;
         end else if (cnt_stb) begin
            active     <= 1'b1;
            strobe_cnt <= wrap ? '0 : strobe_cnt + count_t'(1);
         end
      end
   end

endmodule

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder
   import bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    sw_d,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o,
   output wb_req_t unit_req_o [N_UNITS],
   input  wb_rsp_t unit_rsp_i [N_UNITS]
);

   unit_t              unit;      // Decoded from the live address
   unit_t              sel_q;     // Unit that owes the ack
   logic [N_UNITS-1:0] acks;

   assign unit = wb_i.adr[WB_AW-1 -: 2];

   //--------------------------------------------------------------------------
   // Request fan-out, only the selected unit sees stb
   //--------------------------------------------------------------------------
   always_comb begin
      for (int u = 0; u < N_UNITS; u++) begin
         unit_req_o[u]     = wb_i;
         unit_req_o[u].stb = wb_i.stb && (unit == unit_t'(u));
      end
   end

   // Captured with the request, held through the ack
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d)
         sel_q <= UNIT_VIS0;
      else if (wb_i.cyc && wb_i.stb)
         sel_q <= unit;
   end

   //--------------------------------------------------------------------------
   // Response mux, combinational pass-through
   //--------------------------------------------------------------------------
   assign wb_o = unit_rsp_i[sel_q];

   always_comb begin
      for (int u = 0; u < N_UNITS; u++)
         acks[u] = unit_rsp_i[u].ack;
   end

   a_one_ack: assert property (@(posedge clk_i) disable iff (sw_d)
      $onehot0(acks));

endmodule

// ==== rtl/correlator_top.sv ====
`timescale 1ns/10ps

module correlator_top
   import corr_pkg::*;
   import bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    sw_d,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o,
   input  logic    strobe_i,
   input  ant_t    antenna_i
);

   wb_req_t unit_req [N_UNITS];
   wb_rsp_t unit_rsp [N_UNITS];
   sample_t sample;     // Hilbert output to all accumulators
   logic    enable;
   logic    swap;       // Bank swap pulse

   //--------------------------------------------------------------------------
   // Bus and control
   //--------------------------------------------------------------------------
   bus_decoder u_bus_decoder (
      .clk_i      (clk_i),
      .sw_d       (sw_d),
      .wb_i       (wb_i),
      .wb_o       (wb_o),
      .unit_req_o (unit_req),
      .unit_rsp_i (unit_rsp)
   );

   acq_control u_acq_control (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .strobe_i (strobe_i),
      .enable_o (enable),
      .swap_o   (swap),
      .wb_i     (unit_req[UNIT_CTRL]),
      .wb_o     (unit_rsp[UNIT_CTRL])
   );

   hilbert_approx u_hilbert (
      .clk_i     (clk_i),
      .sw_d      (sw_d),
      .enable_i  (enable),
      .strobe_i  (strobe_i),
      .antenna_i (antenna_i),
      .sample_o  (sample)
   );

   //--------------------------------------------------------------------------
   // Accumulator units
   //--------------------------------------------------------------------------
   vis_block #(.BLOCK_ID(0)) u_vis0 (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .sample_i (sample),
      .swap_i   (swap),
      .wb_i     (unit_req[UNIT_VIS0]),
      .wb_o     (unit_rsp[UNIT_VIS0])
   );

   vis_block #(.BLOCK_ID(1)) u_vis1 (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .sample_i (sample),
      .swap_i   (swap),
      .wb_i     (unit_req[UNIT_VIS1]),
      .wb_o     (unit_rsp[UNIT_VIS1])
   );

   ones_counter u_ones (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .sample_i (sample),
      .swap_i   (swap),
      .wb_i     (unit_req[UNIT_ONES]),
      .wb_o     (unit_rsp[UNIT_ONES])
   );

endmodule

// ==== verification/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//-----------------------------------------------------------------------------
// Bus access
//-----------------------------------------------------------------------------
// Unit code on top, register or pair index below
function automatic logic [WB_AW-1:0] reg_addr(input unit_t unit, input int idx);
   return {unit, 6'(idx)};
endfunction

// One classic cycle, request held until ack then dropped
task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                          input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
   int waited = 0;
   rdat = '0;
   @(posedge clk_i);
   #1;
   wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
   do begin
      @(posedge clk_i);
      #1;                                         // Ack settled after the edge
      waited++;
   end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
   if (wb_rsp.ack)
      rdat = wb_rsp.dat;
   else begin
      $display("No ack within %0d cycles for %s at address 0x%h",
               BUS_TIMEOUT, we ? "write" : "read", adr);
      n_timeout++;
   end
   wb_req = '0;                                   // stb low for at least a cycle
endtask

task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
   logic [WB_DW-1:0] unused;
   bus_access(1'b1, adr, dat, unused);
endtask

task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
   bus_access(1'b0, adr, '0, dat);
endtask

//-----------------------------------------------------------------------------
// Compare tasks
//-----------------------------------------------------------------------------
task automatic check_word(input string name, input logic [WB_DW-1:0] got,
                          input logic [WB_DW-1:0] exp);
   n_checks++;
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      n_mismatch++;
   end
endtask

task automatic check_count(input string name, input count_t got, input count_t exp);
   n_checks++;
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      n_mismatch++;
   end
endtask

// Poll the completed-block count until it reaches target
task automatic wait_block(input count_t target);
   logic [WB_DW-1:0] rd;
   int               polls = 0;
   do begin
      wb_read(reg_addr(UNIT_CTRL, REG_BLOCKCNT), rd);
      polls++;
   end while (count_t'(rd) < target && polls < POLL_LIMIT);
   if (count_t'(rd) < target) begin
      $display("Block count stuck at %0d after %0d reads, waiting for %0d",
               count_t'(rd), polls, target);
      n_timeout++;
   end else
      check_count("block_count", count_t'(rd), target);
endtask

`endif

// ==== verification/correlator_tb.sv ====
`timescale 1ns/10ps

module correlator_tb
   import corr_pkg::*;
   import bus_pkg::*;
();

   localparam int BUS_TIMEOUT = 20;   // Cycles allowed for an ack
   localparam int POLL_LIMIT  = 40;   // Block count reads before giving up
   localparam int BLOCK_LEN   = 16;   // Reset blocksize 15, plus one

   logic    clk_i;
   logic    sw_d;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   logic    strobe;
   ant_t    antenna;

   int n_checks;
   int n_mismatch;
   int n_timeout;

   //--------------------------------------------------------------------------
   // Reference model state
   //--------------------------------------------------------------------------
   int     pair_a   [N_ALL_PAIRS];   // Own baseline table, lexical order
   int     pair_b   [N_ALL_PAIRS];
   count_t cur_cos  [N_ALL_PAIRS];   // Block being counted
   count_t cur_sin  [N_ALL_PAIRS];
   count_t cur_ones [N_ANT];
   count_t exp_cos  [N_ALL_PAIRS];   // Last completed block
   count_t exp_sin  [N_ALL_PAIRS];
   count_t exp_ones [N_ANT];
   ant_t   prev_re;                  // Quadrature history
   logic   primed;
   int     in_block;                 // Strobes so far in this block

   initial clk_i = 1'b0;
   always #4 clk_i = ~clk_i;         // 8 ns period

   correlator_top u_dut (
      .clk_i     (clk_i),
      .sw_d      (sw_d),
      .wb_i      (wb_req),
      .wb_o      (wb_rsp),
      .strobe_i  (strobe),
      .antenna_i (antenna)
   );

   `include "tb_tasks.svh"

   task automatic build_pairs();
      int p = 0;
      for (int a = 0; a < N_ANT; a++) begin
         for (int b = a + 1; b < N_ANT; b++) begin
            pair_a[p] = a;
            pair_b[p] = b;
            p++;
         end
      end
   endtask

   task automatic clear_current();
      foreach (cur_cos[p]) begin
         cur_cos[p] = '0;
         cur_sin[p] = '0;
      end
      foreach (cur_ones[a])
         cur_ones[a] = '0;
   endtask

   // Enable just rose, history and strobe count start over
   task automatic model_restart();
      primed   = 1'b0;
      prev_re  = '0;
      in_block = 0;
      clear_current();
   endtask

   task automatic model_strobe(input ant_t re);
      ant_t im;
      im = primed ? prev_re : '0;      // Zero on the first strobe
      for (int p = 0; p < N_ALL_PAIRS; p++) begin
         cur_cos[p] += count_t'(re[pair_a[p]] == re[pair_b[p]]);
         cur_sin[p] += count_t'(re[pair_a[p]] == im[pair_b[p]]);
      end
      for (int a = 0; a < N_ANT; a++)
         cur_ones[a] += count_t'(re[a]);
      prev_re = re;
      primed  = 1'b1;
      in_block++;
      if (in_block == BLOCK_LEN) begin   // Block done, results become readable
         exp_cos  = cur_cos;
         exp_sin  = cur_sin;
         exp_ones = cur_ones;
         in_block = 0;
         clear_current();
      end
   endtask

   // Back-to-back strobes, one random word each
   task automatic feed_strobes(input int n);
      ant_t word;
      for (int i = 0; i < n; i++) begin
         @(posedge clk_i);
         #1;
         word    = ant_t'($urandom);
         strobe  = 1'b1;
         antenna = word;
         model_strobe(word);
      end
      @(posedge clk_i);
      #1;
      strobe = 1'b0;
   endtask

   // All 28 baselines across both blocks, then the ones counts
   task automatic check_results();
      logic [WB_DW-1:0] rd;
      unit_t            unit;
      for (int p = 0; p < N_ALL_PAIRS; p++) begin
         unit = (p < N_PAIRS) ? UNIT_VIS0 : UNIT_VIS1;
         wb_read(reg_addr(unit, p % N_PAIRS), rd);
         check_count($sformatf("cos[%0d]", p), rd[15:0], exp_cos[p]);
         check_count($sformatf("sin[%0d]", p), rd[31:16], exp_sin[p]);
      end
      for (int a = 0; a < N_ANT; a++) begin
         wb_read(reg_addr(UNIT_ONES, a), rd);
         check_word($sformatf("ones[%0d]", a), rd, WB_DW'(exp_ones[a]));
      end
   endtask

   //--------------------------------------------------------------------------
   // Directed tests
   //--------------------------------------------------------------------------
   task automatic test_registers();
      logic [WB_DW-1:0] rd;
      wb_read(reg_addr(UNIT_CTRL, REG_BLOCKSIZE), rd);
      check_word("blocksize", rd, 32'd15);        // Reset value
      wb_write(reg_addr(UNIT_CTRL, REG_BLOCKSIZE), 32'd7);
      wb_read(reg_addr(UNIT_CTRL, REG_BLOCKSIZE), rd);
      check_word("blocksize", rd, 32'd7);
      wb_write(reg_addr(UNIT_CTRL, REG_CTRL), 32'd1);
      wb_read(reg_addr(UNIT_CTRL, REG_CTRL), rd);
      check_word("ctrl", rd, 32'd1);
      wb_write(reg_addr(UNIT_CTRL, REG_CTRL), 32'd0);   // Disarm, no strobes seen
      wb_write(reg_addr(UNIT_CTRL, REG_BLOCKCNT), 32'h55);
      wb_read(reg_addr(UNIT_CTRL, REG_BLOCKCNT), rd);
      check_word("block_count", rd, 32'd0);       // Read-only
      wb_write(reg_addr(UNIT_CTRL, REG_BLOCKSIZE), 32'd15);
   endtask

   task automatic test_first_block();
      model_restart();
      wb_write(reg_addr(UNIT_CTRL, REG_CTRL), 32'd1);
      feed_strobes(BLOCK_LEN);
      wait_block(count_t'(1));
      check_results();
   endtask

   // Half a block in flight must not disturb the readable bank
   task automatic test_double_buffer();
      feed_strobes(BLOCK_LEN / 2);
      check_results();
      feed_strobes(BLOCK_LEN - BLOCK_LEN / 2);
      wait_block(count_t'(2));
      check_results();                            // Second block from zero
      feed_strobes(BLOCK_LEN);
      wait_block(count_t'(3));
      check_results();                            // Reused bank starts from zero
   endtask

   task automatic test_unmapped();
      logic [WB_DW-1:0] rd;
      wb_read(reg_addr(UNIT_VIS0, 20), rd);
      check_word("vis0[20]", rd, 32'd0);
      wb_read(reg_addr(UNIT_ONES, 12), rd);
      check_word("ones[12]", rd, 32'd0);
   endtask

   initial begin
      void'($urandom(33396));
      n_checks   = 0;
      n_mismatch = 0;
      n_timeout  = 0;
      sw_d       = 1'b1;
      wb_req     = '0;
      strobe     = 1'b0;
      antenna    = '0;
      build_pairs();
      model_restart();
      repeat (16) @(posedge clk_i);
      #1;
      sw_d = 1'b0;

      test_registers();
      test_first_block();
      test_double_buffer();
      test_unmapped();

      $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
               n_checks, n_mismatch, n_timeout);
      if (n_mismatch == 0 && n_timeout == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+verification
rtl/corr_pkg.sv
rtl/bus_pkg.sv
rtl/hilbert_approx.sv
rtl/vis_block.sv
rtl/ones_counter.sv
rtl/acq_control.sv
rtl/bus_decoder.sv
rtl/correlator_top.sv
verification/correlator_tb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = correlator_tb
RTL_TOP   = correlator_top
FILELIST  = sim.f
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
